// ==== Makefile ====
TOP = tb_snake_startscreen

.PHONY: sim clean

sim:
	verilator --binary --assert -Wno-fatal --timescale 1ns/1ps --top-module $(TOP) -f snake_startscreen.f
	out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "Finished with no errors"

clean:
	rm -rf obj_dir

// ==== common/gfx_cmd_pkg.sv ====
package gfx_cmd_pkg;

    // field widths of the renderer command word
    localparam int op_w      = 4;
    localparam int h_phy_w   = 10;
    localparam int v_phy_w   = 9;
    localparam int h_logic_w = 5;
    localparam int v_logic_w = 5;
    localparam int color_w   = 8;
    localparam int glyph_w   = 8;
    localparam int scale_w   = 4;
    localparam int tag_w     = 8;

    // logic grid is 32 x 24 cells on the 640 x 480 screen
    localparam int h_logic_max = 31;
    localparam int v_logic_max = 23;

    typedef logic [31:0]          cmd_t;
    typedef logic [op_w-1:0]      opcode_t;
    typedef logic [h_phy_w-1:0]   phy_x_t;
    typedef logic [v_phy_w-1:0]   phy_y_t;
    typedef logic [h_logic_w-1:0] logic_x_t;
    typedef logic [v_logic_w-1:0] logic_y_t;
    typedef logic [color_w-1:0]   color_t;
    typedef logic [glyph_w-1:0]   glyph_t;
    typedef logic [scale_w-1:0]   scale_t;

    localparam opcode_t op_clear = 4'h1;
    localparam opcode_t op_line  = 4'h9;
    localparam opcode_t op_text  = 4'ha;

    localparam logic [tag_w-1:0] style_tag = 8'd1;    // marks the second word of a glyph

    typedef struct packed {
        opcode_t  opcode;
        logic_x_t x0;
        logic_y_t y0;
        logic_x_t x1;
        logic_y_t y1;
        color_t   color;
    } clear_cmd_t;

    // a segment is two of these, last low for the start point and high for the end point
    typedef struct packed {
        opcode_t opcode;
        phy_x_t  x;
        phy_y_t  y;
        color_t  color;
        logic    last;
    } line_cmd_t;

    typedef struct packed {
        opcode_t opcode;
        phy_x_t  x;
        phy_y_t  y;
        glyph_t  glyph;
        logic    flag;
    } text_place_t;

    typedef struct packed {
        opcode_t          opcode;
        color_t           fg;
        color_t           bg;
        scale_t           scale;
        logic [tag_w-1:0] tag;
    } text_style_t;

    // one text word is either the glyph position or its style
    typedef union packed {
        text_place_t place;
        text_style_t style;
    } text_cmd_u;

endpackage

// ==== common/menu_pkg.sv ====
package menu_pkg;

    typedef enum logic [1:0] {
        draw_start,
        draw_nav,
        draw_settings
    } screen_e;

    typedef struct packed {
        logic       opt_sel;    // 0 is START, 1 is SETTINGS
        logic [1:0] row_sel;    // settings row, 3 is OK
        logic [2:0] level;
    } menu_view_t;

    typedef enum logic [1:0] {
        wk_clear,
        wk_place,
        wk_style,
        wk_line
    } word_kind_e;

    typedef struct packed {
        word_kind_e            kind;
        gfx_cmd_pkg::phy_x_t   x;
        gfx_cmd_pkg::phy_y_t   y;
        gfx_cmd_pkg::glyph_t   glyph;
        gfx_cmd_pkg::color_t   color;
        gfx_cmd_pkg::scale_t   scale;
        logic                  last;
    } word_spec_t;

    typedef logic [6:0] word_idx_t;

    localparam word_idx_t n_start_words    = 7'd39;
    localparam word_idx_t n_nav_words      = 7'd4;
    localparam word_idx_t n_settings_words = 7'd75;

    localparam gfx_cmd_pkg::color_t col_sel   = 8'h3c;
    localparam gfx_cmd_pkg::color_t col_off   = 8'hff;
    localparam gfx_cmd_pkg::color_t col_hi    = 8'h03;
    localparam gfx_cmd_pkg::color_t col_lo    = 8'h00;
    localparam gfx_cmd_pkg::color_t col_title = 8'he0;
    localparam gfx_cmd_pkg::color_t col_bg    = 8'hff;    // screen and glyph background

    localparam gfx_cmd_pkg::phy_x_t glyph_pitch = 10'd12;
    localparam gfx_cmd_pkg::scale_t text_scale  = 4'd1;
    localparam gfx_cmd_pkg::phy_x_t title_pitch = 10'd100;
    localparam gfx_cmd_pkg::scale_t title_scale = 4'hf;

    // start screen
    localparam gfx_cmd_pkg::phy_x_t title_x     = 10'd70;
    localparam gfx_cmd_pkg::phy_y_t title_y     = 9'd120;
    localparam gfx_cmd_pkg::phy_x_t opt_start_x = 10'd290;
    localparam gfx_cmd_pkg::phy_y_t opt_start_y = 9'd340;
    localparam gfx_cmd_pkg::phy_x_t opt_set_x   = 10'd272;
    localparam gfx_cmd_pkg::phy_y_t opt_set_y   = 9'd365;
    localparam gfx_cmd_pkg::phy_x_t ul_start_x0 = 10'd290;
    localparam gfx_cmd_pkg::phy_x_t ul_start_x1 = 10'd350;
    localparam gfx_cmd_pkg::phy_y_t ul_start_y  = 9'd362;
    localparam gfx_cmd_pkg::phy_x_t ul_set_x0   = 10'd272;
    localparam gfx_cmd_pkg::phy_x_t ul_set_x1   = 10'd368;
    localparam gfx_cmd_pkg::phy_y_t ul_set_y    = 9'd387;

    // settings screen, colons and values line up in columns
    localparam gfx_cmd_pkg::phy_x_t set_title_x = 10'd20;
    localparam gfx_cmd_pkg::phy_y_t set_title_y = 9'd20;
    localparam gfx_cmd_pkg::phy_x_t set_row_x   = 10'd48;
    localparam gfx_cmd_pkg::phy_x_t set_colon_x = 10'd108;
    localparam gfx_cmd_pkg::phy_x_t set_value_x = 10'd132;
    localparam gfx_cmd_pkg::phy_y_t set_mode_y  = 9'd60;
    localparam gfx_cmd_pkg::phy_y_t set_level_y = 9'd100;
    localparam gfx_cmd_pkg::phy_y_t set_map_y   = 9'd140;
    localparam gfx_cmd_pkg::phy_x_t set_ok_x    = 10'd194;
    localparam gfx_cmd_pkg::phy_y_t set_ok_y    = 9'd200;

endpackage

// ==== snake_startscreen.f ====
common/gfx_cmd_pkg.sv
common/menu_pkg.sv
startscreen/menu_ctrl.sv
startscreen/screen_script.sv
startscreen/cmd_word_gen.sv
startscreen/snake_startscreen.sv
tb/snake_startscreen_props.sv
tb/tb_snake_startscreen.sv

// ==== startscreen/cmd_word_gen.sv ====
module cmd_word_gen (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 enb,
    input  menu_pkg::word_spec_t spec,
    input  logic                 spec_vld,
    output gfx_cmd_pkg::cmd_t    cmd,
    output logic                 cmd_vld
);
    import gfx_cmd_pkg::*;
    import menu_pkg::*;

    clear_cmd_t clr;
    line_cmd_t  ln;
    text_cmd_u  txt;
    cmd_t       word;
    cmd_t       cmd_q;
    logic       vld_q;

    always_comb begin
        clr.opcode = op_clear;
        clr.x0     = '0;
        clr.y0     = '0;
        clr.x1     = h_logic_w'(h_logic_max);    // whole logic grid
        clr.y1     = v_logic_w'(v_logic_max);
        clr.color  = spec.color;
    end

    assign ln = '{op_line, spec.x, spec.y, spec.color, spec.last};

    // a glyph is a placement word followed by its style word
    always_comb begin
        if (spec.kind == wk_style) begin
            txt.style.opcode = op_text;
            txt.style.fg     = spec.color;
            txt.style.bg     = col_bg;
            txt.style.scale  = spec.scale;
            txt.style.tag    = style_tag;
        end else begin
            txt.place.opcode = op_text;
            txt.place.x      = spec.x;
            txt.place.y      = spec.y;
            txt.place.glyph  = spec.glyph;
            txt.place.flag   = 1'b0;
        end
    end

    always_comb begin
        unique case (spec.kind)
            wk_clear: word = cmd_t'(clr);
            wk_line:  word = cmd_t'(ln);
            default:  word = cmd_t'(txt);
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            vld_q <= 1'b0;
        end else if (enb) begin
            vld_q <= spec_vld;
        end
    end

    always_ff @(posedge clk) begin
        if (enb) begin
            cmd_q <= word;
        end
    end

    // a word held over a low enb cycle goes out on the next high one
    assign cmd     = cmd_q;
    assign cmd_vld = vld_q & enb;

endmodule

// ==== startscreen/menu_ctrl.sv ====
module menu_ctrl (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 enb,
    input  logic                 up,
    input  logic                 down,
    input  logic                 right,
    input  logic                 burst_done,
    output logic                 draw_req,
    output menu_pkg::screen_e    screen,
    output menu_pkg::menu_view_t view,
    output logic                 start
);
    import menu_pkg::*;

    typedef enum logic {
        st_idle,
        st_draw
    } state_e;

    state_e     state;
    logic       init;
    logic       set_open;
    logic       opt_sel;
    logic [1:0] row_sel;
    logic [2:0] level;
    logic       set_step;

    // any key that redraws the settings screen without leaving it
    assign set_step = up | down | (right & (row_sel == 2'd1));

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= st_idle;
            init     <= 1'b1;
            set_open <= 1'b0;
            opt_sel  <= 1'b0;
            row_sel  <= 2'd0;
            level    <= 3'd1;
            screen   <= draw_start;
        end else if (enb) begin
            if (state == st_draw) begin
                if (burst_done) begin
                    state <= st_idle;    // keys during a burst are dropped
                end
            end else if (init) begin
                init   <= 1'b0;
                screen <= draw_start;
                state  <= st_draw;
            end else if (!set_open && (up || down)) begin
                opt_sel <= ~opt_sel;
                screen  <= draw_nav;
                state   <= st_draw;
            end else if (set_open && right && (row_sel == 2'd3)) begin
                set_open <= 1'b0;
                row_sel  <= 2'd0;
                screen   <= draw_start;
                state    <= st_draw;
            end else if (set_open && set_step) begin
                if (up) begin
                    row_sel <= row_sel - 2'd1;
                end else if (down) begin
                    row_sel <= row_sel + 2'd1;
                end else begin
                    level <= level + 3'd1;    // wraps from 7 to 0
                end
                screen <= draw_settings;
                state  <= st_draw;
            end else if (!set_open && opt_sel && right) begin
                set_open <= 1'b1;
                screen   <= draw_settings;
                state    <= st_draw;
            end
        end
    end

    assign draw_req = (state == st_draw);

    assign view.opt_sel = opt_sel;
    assign view.row_sel = row_sel;
    assign view.level   = level;

    // start is not held back by enb or by a burst in flight
    assign start = right & ~opt_sel & ~set_open;

endmodule

// ==== startscreen/screen_script.sv ====
module screen_script #(
    parameter logic [7:0] glyph_base = 8'h30
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 enb,
    input  logic                 draw_req,
    input  menu_pkg::screen_e    screen,
    input  menu_pkg::menu_view_t view,
    output menu_pkg::word_spec_t spec,
    output logic                 spec_vld,
    output logic                 burst_done
);
    import gfx_cmd_pkg::*;
    import menu_pkg::*;

    typedef struct packed {
        logic [5:0]  first;    // index of the first character of the run
        logic [63:0] str;
        logic [3:0]  len;
        phy_x_t      x;
        phy_y_t      y;
        color_t      col;
        scale_t      scale;
        phy_x_t      pitch;
    } run_t;

    localparam logic [39:0] str_title    = "SNAKE";
    localparam logic [39:0] str_start    = "START";
    localparam logic [63:0] str_settings = "SETTINGS";
    localparam logic [31:0] str_mode     = "MODE";
    localparam logic [55:0] str_classic  = "Classic";
    localparam logic [39:0] str_level    = "LEVEL";
    localparam logic [23:0] str_map      = "MAP";
    localparam logic [31:0] str_none     = "None";
    localparam logic [15:0] str_ok       = "OK";
    localparam logic [7:0]  str_colon    = ":";

    word_idx_t  cnt;
    word_idx_t  last_idx;
    logic [5:0] ch;
    logic [3:0] k;
    run_t       run;
    color_t     row_col [4];
    glyph_t     level_glyph;
    logic       seg;
    logic       end_pt;

    function automatic run_t mk_run(input logic [5:0] first, input logic [63:0] str,
                                    input logic [3:0] len, input phy_x_t x, input phy_y_t y,
                                    input color_t col);
        run_t r;
        r = '{first, str, len, x, y, col, text_scale, glyph_pitch};
        return r;
    endfunction

    always_ff @(posedge clk) begin
        if (rst || !draw_req) begin
            cnt <= '0;
        end else if (enb) begin
            cnt <= cnt + 7'd1;
        end
    end

    always_comb begin
        unique case (screen)
            draw_start: last_idx = n_start_words - 7'd1;
            draw_nav:   last_idx = n_nav_words - 7'd1;
            default:    last_idx = n_settings_words - 7'd1;
        endcase
    end

    assign spec_vld   = draw_req;
    assign burst_done = draw_req & enb & (cnt == last_idx);

    always_comb begin
        for (int r = 0; r < 4; r++) begin
            row_col[r] = (view.row_sel == 2'(r)) ? col_hi : col_lo;
        end
    end

    assign level_glyph = glyph_base + 8'd1 + {5'd0, view.level};

    // character index, two words per character after the clear word
    assign ch = 6'((cnt - 7'd1) >> 1);

    always_comb begin
        if (screen == draw_start) begin
            if (ch < 6'd5) begin
                run       = mk_run(6'd0, str_title, 4'd5, title_x, title_y, col_title);
                run.scale = title_scale;
                run.pitch = title_pitch;
            end else if (ch < 6'd10) begin
                run = mk_run(6'd5, str_start, 4'd5, opt_start_x, opt_start_y, col_hi);
            end else begin
                run = mk_run(6'd10, str_settings, 4'd8, opt_set_x, opt_set_y, col_hi);
            end
        end else if (ch < 6'd8) begin
            run = mk_run(6'd0, str_settings, 4'd8, set_title_x, set_title_y, col_sel);
        end else if (ch < 6'd12) begin
            run = mk_run(6'd8, str_mode, 4'd4, set_row_x, set_mode_y, row_col[0]);
        end else if (ch == 6'd12) begin
            run = mk_run(6'd12, str_colon, 4'd1, set_colon_x, set_mode_y, row_col[0]);
        end else if (ch < 6'd20) begin
            run = mk_run(6'd13, str_classic, 4'd7, set_value_x, set_mode_y, row_col[0]);
        end else if (ch < 6'd25) begin
            run = mk_run(6'd20, str_level, 4'd5, set_row_x, set_level_y, row_col[1]);
        end else if (ch == 6'd25) begin
            run = mk_run(6'd25, str_colon, 4'd1, set_colon_x, set_level_y, row_col[1]);
        end else if (ch == 6'd26) begin
            run = mk_run(6'd26, {56'd0, level_glyph}, 4'd1, set_value_x, set_level_y,
                         row_col[1]);
        end else if (ch < 6'd30) begin
            run = mk_run(6'd27, str_map, 4'd3, set_row_x, set_map_y, row_col[2]);
        end else if (ch == 6'd30) begin
            run = mk_run(6'd30, str_colon, 4'd1, set_colon_x, set_map_y, row_col[2]);
        end else if (ch < 6'd35) begin
            run = mk_run(6'd31, str_none, 4'd4, set_value_x, set_map_y, row_col[2]);
        end else begin
            run = mk_run(6'd35, str_ok, 4'd2, set_ok_x, set_ok_y, row_col[3]);
        end
        k = 4'(ch - run.first);
    end

    // the start screen only draws the underline of the selected option
    assign seg    = (screen == draw_nav) ? cnt[1] : view.opt_sel;
    assign end_pt = (screen == draw_nav) ? cnt[0] : (cnt == last_idx);

    always_comb begin
        spec = '0;
        if (screen == draw_nav || (screen == draw_start && cnt >= n_start_words - 7'd2)) begin
            spec.kind  = wk_line;
            spec.x     = seg ? (end_pt ? ul_set_x1 : ul_set_x0)
                             : (end_pt ? ul_start_x1 : ul_start_x0);
            spec.y     = seg ? ul_set_y : ul_start_y;
            spec.color = (seg == view.opt_sel) ? col_sel : col_off;
            spec.last  = end_pt;
        end else if (cnt == 7'd0) begin
            spec.kind  = wk_clear;
            spec.color = col_bg;
        end else begin
            spec.kind  = cnt[0] ? wk_place : wk_style;
            spec.x     = run.x + k * run.pitch;
            spec.y     = run.y;
            spec.glyph = run.str[8 * (run.len - 4'd1 - k) +: 8];
            spec.color = run.col;
            spec.scale = run.scale;
        end
    end

endmodule

// ==== startscreen/snake_startscreen.sv ====
module snake_startscreen #(
    parameter logic [7:0] glyph_base = 8'h30    // digit zero minus one in the font table
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              enb,
    input  logic              up,
    input  logic              down,
    input  logic              left,
    input  logic              right,
    output logic              start,
    output gfx_cmd_pkg::cmd_t cmd,
    output logic              cmd_vld
);
    import menu_pkg::*;

    logic       draw_req;
    screen_e    screen;
    menu_view_t view;
    word_spec_t spec;
    logic       spec_vld;
    logic       burst_done;

    menu_ctrl u_menu_ctrl (
        .clk        (clk),
        .rst        (rst),
        .enb        (enb),
        .up         (up),
        .down       (down),
        .right      (right),
        .burst_done (burst_done),
        .draw_req   (draw_req),
        .screen     (screen),
        .view       (view),
        .start      (start)
    );

    screen_script #(
        .glyph_base (glyph_base)
    ) u_screen_script (
        .clk        (clk),
        .rst        (rst),
        .enb        (enb),
        .draw_req   (draw_req),
        .screen     (screen),
        .view       (view),
        .spec       (spec),
        .spec_vld   (spec_vld),
        .burst_done (burst_done)
    );

    cmd_word_gen u_cmd_word_gen (
        .clk      (clk),
        .rst      (rst),
        .enb      (enb),
        .spec     (spec),
        .spec_vld (spec_vld),
        .cmd      (cmd),
        .cmd_vld  (cmd_vld)
    );

endmodule

// ==== tb/snake_startscreen_props.sv ====
module snake_startscreen_props (
    input logic              clk,
    input logic              rst,
    input logic              enb,
    input logic              right,
    input logic              start,
    input gfx_cmd_pkg::cmd_t cmd,
    input logic              cmd_vld
);
    timeunit 1ns;
    timeprecision 100ps;
    import gfx_cmd_pkg::*;

    int        n_fail = 0;    // read by the testbench at the end of the run
    text_cmd_u txt;
    logic      is_place;
    logic      is_style;
    logic      style_due;

    assign txt      = cmd;
    assign is_place = (txt.place.opcode == op_text) && !txt.place.flag;
    assign is_style = (txt.style.opcode == op_text) && (txt.style.tag == style_tag);

    always_ff @(posedge clk) begin
        if (rst) begin
            style_due <= 1'b0;
        end else if (cmd_vld) begin
            style_due <= is_place;    // next valid word must carry the style
        end
    end

    a_vld_needs_enb: assert property (@(posedge clk) disable iff (rst) !enb |-> !cmd_vld)
        else begin
            n_fail++;
            $error("cmd_vld is high in a cycle with enb low");
        end

    a_start_needs_right: assert property (@(posedge clk) disable iff (rst) start |-> right)
        else begin
            n_fail++;
            $error("start is high while right is low");
        end

    a_style_after_place: assert property (
        @(posedge clk) disable iff (rst) (cmd_vld && style_due) |-> is_style)
        else begin
            n_fail++;
            $error("a placement word is not followed by a style word");
        end

endmodule

// ==== tb/tb_snake_startscreen.sv ====
module tb_snake_startscreen;
    timeunit 1ns;
    timeprecision 100ps;
    import gfx_cmd_pkg::*;
    import menu_pkg::*;

    localparam logic [7:0] glyph_base = 8'h30;
    localparam int burst_timeout = 1000;
    localparam int quiet_cycles  = 12;

    localparam int key_up    = 0;
    localparam int key_down  = 1;
    localparam int key_right = 2;

    localparam int scr_none     = 0;
    localparam int scr_start    = 1;
    localparam int scr_nav      = 2;
    localparam int scr_settings = 3;

    logic clk;
    logic rst;
    logic enb;
    logic up;
    logic down;
    logic left;
    logic right;
    logic start;
    cmd_t cmd;
    logic cmd_vld;

    // expected menu registers, updated from the key history
    logic       m_opt_sel;
    logic       m_set_open;
    logic [1:0] m_row;
    logic [2:0] m_level;

    cmd_t   exp_q[$];
    int     errors;
    int     n_checks;
    integer seed;
    logic   enb_rand;
    logic   start_seen;

    snake_startscreen #(
        .glyph_base (glyph_base)
    ) u_dut (
        .clk     (clk),
        .rst     (rst),
        .enb     (enb),
        .up      (up),
        .down    (down),
        .left    (left),
        .right   (right),
        .start   (start),
        .cmd     (cmd),
        .cmd_vld (cmd_vld)
    );

    bind snake_startscreen snake_startscreen_props u_props (
        .clk     (clk),
        .rst     (rst),
        .enb     (enb),
        .right   (right),
        .start   (start),
        .cmd     (cmd),
        .cmd_vld (cmd_vld)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // enb alternates high and low stretches of 1 to 4 cycles while stalling is on
    initial begin
        int   stretch;
        logic lvl;
        stretch = 0;
        lvl     = 1'b1;
        forever begin
            @(posedge clk);
            #5;
            if (!enb_rand) begin
                enb = 1'b1;
            end else begin
                if (stretch == 0) begin
                    lvl     = ~lvl;
                    stretch = 1 + ($unsigned($random(seed)) % 4);
                end
                enb = lvl;
                stretch--;
            end
        end
    end

    function automatic cmd_t place_word(input phy_x_t x, input phy_y_t y, input glyph_t g);
        return {op_text, x, y, g, 1'b0};
    endfunction

    function automatic cmd_t style_word(input color_t fg, input scale_t scale);
        return {op_text, fg, col_bg, scale, 8'd1};
    endfunction

    function automatic cmd_t line_word(input phy_x_t x, input phy_y_t y, input color_t col,
                                       input logic last);
        return {op_line, x, y, col, last};
    endfunction

    function automatic cmd_t clear_word();
        return {op_clear, 5'd0, 5'd0, 5'd31, 5'd23, col_bg};
    endfunction

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        n_checks++;
        if (exp !== act) begin
            errors++;
            $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic push_glyph(input phy_x_t x, input phy_y_t y, input glyph_t g,
                              input color_t col, input scale_t scale);
        exp_q.push_back(place_word(x, y, g));
        exp_q.push_back(style_word(col, scale));
    endtask

    task automatic push_text(input string s, input phy_x_t x, input phy_y_t y,
                             input phy_x_t pitch, input color_t col, input scale_t scale);
        int px;
        for (int k = 0; k < s.len(); k++) begin
            px = int'(x) + k * int'(pitch);
            push_glyph(phy_x_t'(px), y, s[k], col, scale);
        end
    endtask

    task automatic push_underline(input phy_x_t x0, input phy_x_t x1, input phy_y_t y,
                                  input color_t col);
        exp_q.push_back(line_word(x0, y, col, 1'b0));
        exp_q.push_back(line_word(x1, y, col, 1'b1));
    endtask

    task automatic build_start();
        exp_q.push_back(clear_word());
        push_text("SNAKE", title_x, title_y, title_pitch, col_title, title_scale);
        push_text("START", opt_start_x, opt_start_y, glyph_pitch, col_hi, text_scale);
        push_text("SETTINGS", opt_set_x, opt_set_y, glyph_pitch, col_hi, text_scale);
        if (!m_opt_sel) begin
            push_underline(ul_start_x0, ul_start_x1, ul_start_y, col_sel);
        end else begin
            push_underline(ul_set_x0, ul_set_x1, ul_set_y, col_sel);
        end
    endtask

    task automatic build_nav();
        push_underline(ul_start_x0, ul_start_x1, ul_start_y, m_opt_sel ? col_off : col_sel);
        push_underline(ul_set_x0, ul_set_x1, ul_set_y, m_opt_sel ? col_sel : col_off);
    endtask

    task automatic build_settings();
        color_t rc [4];
        for (int r = 0; r < 4; r++) begin
            rc[r] = (int'(m_row) == r) ? col_hi : col_lo;
        end
        exp_q.push_back(clear_word());
        push_text("SETTINGS", set_title_x, set_title_y, glyph_pitch, col_sel, text_scale);
        push_text("MODE", set_row_x, set_mode_y, glyph_pitch, rc[0], text_scale);
        push_text(":", set_colon_x, set_mode_y, glyph_pitch, rc[0], text_scale);
        push_text("Classic", set_value_x, set_mode_y, glyph_pitch, rc[0], text_scale);
        push_text("LEVEL", set_row_x, set_level_y, glyph_pitch, rc[1], text_scale);
        push_text(":", set_colon_x, set_level_y, glyph_pitch, rc[1], text_scale);
        push_glyph(set_value_x, set_level_y, glyph_base + 8'd1 + {5'd0, m_level}, rc[1],
                   text_scale);
        push_text("MAP", set_row_x, set_map_y, glyph_pitch, rc[2], text_scale);
        push_text(":", set_colon_x, set_map_y, glyph_pitch, rc[2], text_scale);
        push_text("None", set_value_x, set_map_y, glyph_pitch, rc[2], text_scale);
        push_text("OK", set_ok_x, set_ok_y, glyph_pitch, rc[3], text_scale);
    endtask

    // menu rules in priority order, gives the screen that the key redraws
    task automatic apply_rules(input int key, output int scr);
        scr = scr_none;
        if (!m_set_open && (key == key_up || key == key_down)) begin
            m_opt_sel = ~m_opt_sel;
            scr       = scr_nav;
        end else if (m_set_open && key == key_right && m_row == 2'd3) begin
            m_set_open = 1'b0;
            m_row      = 2'd0;
            scr        = scr_start;
        end else if (m_set_open && key == key_up) begin
            m_row = m_row - 2'd1;
            scr   = scr_settings;
        end else if (m_set_open && key == key_down) begin
            m_row = m_row + 2'd1;
            scr   = scr_settings;
        end else if (m_set_open && key == key_right && m_row == 2'd1) begin
            m_level = m_level + 3'd1;
            scr     = scr_settings;
        end else if (!m_set_open && m_opt_sel && key == key_right) begin
            m_set_open = 1'b1;
            scr        = scr_settings;
        end
    endtask

    task automatic press_key(input int key);
        @(posedge clk);
        #5;
        case (key)
            key_up:   up = 1'b1;
            key_down: down = 1'b1;
            default:  right = 1'b1;
        endcase
        @(negedge clk);
        start_seen = start;    // start follows right within the key cycle
        @(posedge clk);
        #5;
        up    = 1'b0;
        down  = 1'b0;
        right = 1'b0;
    endtask

    task automatic collect_burst(input string name);
        int   got;
        int   cycles;
        logic started;
        logic done;
        got     = 0;
        cycles  = 0;
        started = 1'b0;
        done    = 1'b0;
        while (!done && cycles < burst_timeout) begin
            @(negedge clk);
            cycles++;
            if (cmd_vld) begin
                started = 1'b1;
                if (got < exp_q.size()) begin
                    check($sformatf("%s word %0d", name, got), exp_q[got], cmd);
                end
                got++;
            end else if (started && enb) begin
                done = 1'b1;
            end
        end
        if (!done) begin
            errors++;
            $display("ERROR %s: timed out waiting for the burst to finish", name);
        end
        check({name, " word count"}, 32'(exp_q.size()), 32'(got));
        exp_q.delete();
    endtask

    task automatic expect_quiet(input string name);
        int seen;
        seen = 0;
        for (int i = 0; i < quiet_cycles; i++) begin
            @(negedge clk);
            if (cmd_vld) begin
                seen++;
            end
        end
        check({name, " no burst"}, 32'd0, 32'(seen));
    endtask

    task automatic key_step(input string name, input int key, input logic stall);
        logic exp_start;
        int   scr;
        exp_start = (key == key_right) && !m_opt_sel && !m_set_open;
        press_key(key);
        check({name, " start"}, {31'd0, exp_start}, {31'd0, start_seen});
        apply_rules(key, scr);
        if (stall) begin
            @(negedge clk);
            enb_rand = 1'b1;
        end
        if (scr == scr_none) begin
            expect_quiet(name);
        end else begin
            if (scr == scr_start) begin
                build_start();
            end else if (scr == scr_nav) begin
                build_nav();
            end else begin
                build_settings();
            end
            collect_burst(name);
        end
        enb_rand = 1'b0;
    endtask

    task automatic test_reset();
        @(negedge clk);
        check("reset outputs", 32'd0, {30'd0, cmd_vld, start});
        build_start();
        collect_burst("reset start screen");
    endtask

    task automatic test_nav();
        key_step("nav down", key_down, 1'b0);
        key_step("nav up", key_up, 1'b0);
        key_step("start key", key_right, 1'b0);
    endtask

    task automatic test_settings();
        key_step("select settings", key_down, 1'b0);
        key_step("open settings", key_right, 1'b0);
        key_step("row to level", key_down, 1'b0);
        for (int i = 0; i < 6; i++) begin
            key_step($sformatf("level up %0d", i), key_right, 1'b0);
        end
        key_step("level wrap", key_right, 1'b0);
    endtask

    task automatic test_ok_return();
        key_step("row up", key_up, 1'b0);
        key_step("row wrap", key_up, 1'b0);
        key_step("ok to start", key_right, 1'b0);
    endtask

    task automatic test_enb_stall();
        key_step("stall nav up", key_up, 1'b1);
        key_step("stall nav down", key_down, 1'b1);
        key_step("stall open settings", key_right, 1'b1);
        key_step("stall row 1", key_down, 1'b1);
        key_step("stall level", key_right, 1'b1);
        key_step("stall row 2", key_down, 1'b1);
        key_step("stall row 3", key_down, 1'b1);
        key_step("stall ok", key_right, 1'b1);
    endtask

    initial begin
        rst        = 1'b1;
        enb        = 1'b1;
        up         = 1'b0;
        down       = 1'b0;
        left       = 1'b0;
        right      = 1'b0;
        enb_rand   = 1'b0;
        seed       = 32'hf2d6;
        errors     = 0;
        n_checks   = 0;
        start_seen = 1'b0;
        m_opt_sel  = 1'b0;
        m_set_open = 1'b0;
        m_row      = 2'd0;
        m_level    = 3'd1;
        repeat (4) @(posedge clk);
        #5;
        rst = 1'b0;
        test_reset();
        test_nav();
        test_settings();
        test_ok_return();
        test_enb_stall();
        $display("checks: %0d, errors: %0d, assertion failures: %0d", n_checks, errors,
                 u_dut.u_props.n_fail);
        if (errors == 0 && u_dut.u_props.n_fail == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule
